// File: logic/raystore_params.svh
`ifndef RAYSTORE_PARAMS_SVH
`define RAYSTORE_PARAMS_SVH

// ray index width
`define RAY_ID_W 6

// one coordinate, single precision bits
`define RAY_COMP_W 32

// number of stored rays
`define RAY_DEPTH 64

`endif

// File: logic/ray_pkg.sv
`default_nettype none

`include "raystore_params.svh"

package ray_pkg;

	typedef logic [`RAY_ID_W-1:0] ray_id_t;

	typedef logic [`RAY_COMP_W-1:0] ray_comp_t;

	// origin first, then direction
	typedef struct packed {
		ray_comp_t ox;
		ray_comp_t oy;
		ray_comp_t oz;
		ray_comp_t dx;
		ray_comp_t dy;
		ray_comp_t dz;
	} ray_vec_t;

endpackage : ray_pkg

`default_nettype wire

// File: logic/arb_pkg.sv
`default_nettype none

package arb_pkg;

	// bit 2 traversal 1, bit 1 traversal 2, bit 0 list cache
	typedef logic [2:0] req_mask_t;
	typedef logic [2:0] grant_mask_t;

	localparam int IDX_T1 = 2;
	localparam int IDX_T2 = 1;
	localparam int IDX_LC = 0;

	// token after reset is {T1,T2}
	localparam grant_mask_t TOKEN_INIT = 3'b110;

	// enum value matches the mask bit of the requester
	typedef enum logic [1:0] {
		SRC_LC = 2'd0,
		SRC_T2 = 2'd1,
		SRC_T1 = 2'd2
	} src_sel_t;

endpackage : arb_pkg

`default_nettype wire

// File: logic/rr_arbiter.sv
`default_nettype none

module rr_arbiter import arb_pkg::*; (
	input logic clk,
	input logic rst_n,
	input req_mask_t req,
	input logic hold,
	output grant_mask_t grant
);

	grant_mask_t token;
	logic all_req;

	// {T1,T2} -> {T2,LC} -> {LC,T1}, one step per cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			token <= TOKEN_INIT;
		end else begin
			token <= {token[0], token[2:1]};
		end
	end

	assign all_req = &req;

	// at most two requesters pass, the token picks when all three ask
	always_comb begin
		if (hold) begin
			grant = '0;
		end else if (all_req) begin
			grant = token;
		end else begin
			grant = req;
		end
	end

endmodule : rr_arbiter

`default_nettype wire

// File: logic/ray_ram.sv
`default_nettype none

`include "raystore_params.svh"

module ray_ram import ray_pkg::*; (
	input logic clk,
	input ray_id_t addr_a,
	input ray_id_t addr_b,
	input logic we_a,
	input ray_vec_t wdata_a,
	output ray_vec_t q_a,
	output ray_vec_t q_b
);

	ray_vec_t mem [`RAY_DEPTH];

	ray_id_t addr_a_q;
	ray_id_t addr_b_q;

	// port a, write plus read
	always_ff @(posedge clk) begin
		if (we_a) begin
			mem[addr_a] <= wdata_a;
		end
		addr_a_q <= addr_a;
		q_a <= mem[addr_a_q];
	end

	// port b, read only
	always_ff @(posedge clk) begin
		addr_b_q <= addr_b;
		q_b <= mem[addr_b_q];
	end

endmodule : ray_ram

`default_nettype wire

// File: logic/ray_load_regs.sv
`default_nettype none

`include "raystore_params.svh"

module ray_load_regs import ray_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic reg_wr,
	input logic [2:0] reg_addr,
	input ray_comp_t reg_wdata,
	output logic ld_we,
	output ray_id_t ld_id,
	output ray_vec_t ld_vec
);

	localparam logic [2:0] COMMIT_ADDR = 3'd7;

	logic commit;

	assign commit = reg_wr && (reg_addr == COMMIT_ADDR);

	// staging registers, host map 0 = id, 1..6 = components
	always_ff @(posedge clk) begin
		if (reg_wr) begin
			case (reg_addr)
				3'd0: ld_id <= reg_wdata[`RAY_ID_W-1:0];
				3'd1: ld_vec.ox <= reg_wdata;
				3'd2: ld_vec.oy <= reg_wdata;
				3'd3: ld_vec.oz <= reg_wdata;
				3'd4: ld_vec.dx <= reg_wdata;
				3'd5: ld_vec.dy <= reg_wdata;
				3'd6: ld_vec.dz <= reg_wdata;
				default: begin
				end
			endcase
		end
	end

	// single cycle write pulse after the commit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_we <= 1'b0;
		end else begin
			ld_we <= commit;
		end
	end

endmodule : ray_load_regs

`default_nettype wire

// File: logic/raystore.sv
`default_nettype none

module raystore import ray_pkg::*, arb_pkg::*; (
	input logic clk,
	input logic rst_n,

	input ray_id_t ttrs1_id,
	input logic ttrs1_re,
	input ray_id_t ttrs2_id,
	input logic ttrs2_re,
	input ray_id_t lctrs_id,
	input logic lctrs_re,

	output logic ttrs1_stall,
	output logic ttrs2_stall,
	output logic lctrs_stall,

	output ray_id_t rstt1_id,
	output ray_vec_t rstt1_vec,
	output logic rstt1_valid,
	output ray_id_t rstt2_id,
	output ray_vec_t rstt2_vec,
	output logic rstt2_valid,
	output ray_id_t rstic_id,
	output ray_vec_t rstic_vec,
	output logic rstic_valid,

	input logic rstt1_stall,
	input logic rstt2_stall,
	input logic rstic_stall,

	input logic ld_we,
	input ray_id_t ld_id,
	input ray_vec_t ld_vec
);

	req_mask_t req;
	grant_mask_t grant;
	grant_mask_t grant_d1;
	grant_mask_t grant_d2;

	src_sel_t sel_a;
	src_sel_t sel_b;
	src_sel_t sel_a_d1;
	src_sel_t sel_a_d2;
	src_sel_t sel_b_d1;
	src_sel_t sel_b_d2;

	ray_id_t id_a;
	ray_id_t id_b;
	ray_id_t id_a_d1;
	ray_id_t id_a_d2;
	ray_id_t id_b_d1;
	ray_id_t id_b_d2;
	ray_id_t addr_a;

	ray_vec_t q_a;
	ray_vec_t q_b;

	// a full output channel drops its requester out of arbitration
	assign req = {ttrs1_re & ~rstt1_stall, ttrs2_re & ~rstt2_stall, lctrs_re & ~rstic_stall};

	rr_arbiter arb_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.hold(ld_we),
		.grant(grant)
	);

	assign ttrs1_stall = ~grant[IDX_T1];
	assign ttrs2_stall = ~grant[IDX_T2];
	assign lctrs_stall = ~grant[IDX_LC];

	// port a takes the lowest granted bit, port b the other one
	always_comb begin
		if (grant[IDX_LC]) begin
			sel_a = SRC_LC;
		end else if (grant[IDX_T2]) begin
			sel_a = SRC_T2;
		end else begin
			sel_a = SRC_T1;
		end

		if (grant[IDX_T1]) begin
			sel_b = SRC_T1;
		end else if (grant[IDX_T2]) begin
			sel_b = SRC_T2;
		end else begin
			sel_b = SRC_LC;
		end
	end

	always_comb begin
		case (sel_a)
			SRC_T1: id_a = ttrs1_id;
			SRC_T2: id_a = ttrs2_id;
			default: id_a = lctrs_id;
		endcase

		case (sel_b)
			SRC_T1: id_b = ttrs1_id;
			SRC_T2: id_b = ttrs2_id;
			default: id_b = lctrs_id;
		endcase
	end

	// load owns port a during its write cycle
	assign addr_a = ld_we ? ld_id : id_a;

	ray_ram ram_i (
		.clk(clk),
		.addr_a(addr_a),
		.addr_b(id_b),
		.we_a(ld_we),
		.wdata_a(ld_vec),
		.q_a(q_a),
		.q_b(q_b)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant_d1 <= '0;
			grant_d2 <= '0;
			sel_a_d1 <= SRC_LC;
			sel_a_d2 <= SRC_LC;
			sel_b_d1 <= SRC_LC;
			sel_b_d2 <= SRC_LC;
		end else begin
			grant_d1 <= grant;
			grant_d2 <= grant_d1;
			sel_a_d1 <= sel_a;
			sel_a_d2 <= sel_a_d1;
			sel_b_d1 <= sel_b;
			sel_b_d2 <= sel_b_d1;
		end
	end

	always_ff @(posedge clk) begin
		id_a_d1 <= id_a;
		id_a_d2 <= id_a_d1;
		id_b_d1 <= id_b;
		id_b_d2 <= id_b_d1;
	end

	// route q back to the channel that asked
	assign rstt1_valid = grant_d2[IDX_T1];
	assign rstt1_id = (sel_a_d2 == SRC_T1) ? id_a_d2 : id_b_d2;
	assign rstt1_vec = (sel_a_d2 == SRC_T1) ? q_a : q_b;

	assign rstt2_valid = grant_d2[IDX_T2];
	assign rstt2_id = (sel_a_d2 == SRC_T2) ? id_a_d2 : id_b_d2;
	assign rstt2_vec = (sel_a_d2 == SRC_T2) ? q_a : q_b;

	assign rstic_valid = grant_d2[IDX_LC];
	assign rstic_id = (sel_b_d2 == SRC_LC) ? id_b_d2 : id_a_d2;
	assign rstic_vec = (sel_b_d2 == SRC_LC) ? q_b : q_a;

endmodule : raystore

`default_nettype wire

// File: logic/raystore_top.sv
`default_nettype none

module raystore_top import ray_pkg::*; (
	input logic clk,
	input logic rst_n,

	input logic reg_wr,
	input logic [2:0] reg_addr,
	input ray_comp_t reg_wdata,

	input ray_id_t ttrs1_id,
	input logic ttrs1_re,
	input ray_id_t ttrs2_id,
	input logic ttrs2_re,
	input ray_id_t lctrs_id,
	input logic lctrs_re,

	output logic ttrs1_stall,
	output logic ttrs2_stall,
	output logic lctrs_stall,

	output ray_id_t rstt1_id,
	output ray_vec_t rstt1_vec,
	output logic rstt1_valid,
	output ray_id_t rstt2_id,
	output ray_vec_t rstt2_vec,
	output logic rstt2_valid,
	output ray_id_t rstic_id,
	output ray_vec_t rstic_vec,
	output logic rstic_valid,

	input logic rstt1_stall,
	input logic rstt2_stall,
	input logic rstic_stall
);

	logic ld_we;
	ray_id_t ld_id;
	ray_vec_t ld_vec;

	ray_load_regs load_i (
		.clk(clk),
		.rst_n(rst_n),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.ld_we(ld_we),
		.ld_id(ld_id),
		.ld_vec(ld_vec)
	);

	raystore store_i (
		.clk(clk),
		.rst_n(rst_n),
		.ttrs1_id(ttrs1_id),
		.ttrs1_re(ttrs1_re),
		.ttrs2_id(ttrs2_id),
		.ttrs2_re(ttrs2_re),
		.lctrs_id(lctrs_id),
		.lctrs_re(lctrs_re),
		.ttrs1_stall(ttrs1_stall),
		.ttrs2_stall(ttrs2_stall),
		.lctrs_stall(lctrs_stall),
		.rstt1_id(rstt1_id),
		.rstt1_vec(rstt1_vec),
		.rstt1_valid(rstt1_valid),
		.rstt2_id(rstt2_id),
		.rstt2_vec(rstt2_vec),
		.rstt2_valid(rstt2_valid),
		.rstic_id(rstic_id),
		.rstic_vec(rstic_vec),
		.rstic_valid(rstic_valid),
		.rstt1_stall(rstt1_stall),
		.rstt2_stall(rstt2_stall),
		.rstic_stall(rstic_stall),
		.ld_we(ld_we),
		.ld_id(ld_id),
		.ld_vec(ld_vec)
	);

endmodule : raystore_top

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule : tb_clock

`default_nettype wire

// File: tests/raystore_chk.sv
`default_nettype none

module raystore_chk import arb_pkg::*; (
	input logic clk,
	input logic rst_n,
	input grant_mask_t grant,
	input logic rstt1_stall,
	input logic rstt2_stall,
	input logic rstic_stall,
	input logic rstt1_valid,
	input logic rstt2_valid,
	input logic rstic_valid,
	input logic ld_we
);

	// a requester whose output channel is full never wins
	stall_vs_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(rstt1_stall && grant[IDX_T1]) && !(rstt2_stall && grant[IDX_T2])
		&& !(rstic_stall && grant[IDX_LC]))
		else $error("grant to a stalled output channel");

	two_grants_max: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(grant) <= 2)
		else $error("more than two grants");

	// results come back two cycles after the grant
	t1_valid_lat: assert property (@(posedge clk) disable iff (!rst_n)
		grant[IDX_T1] |-> ##2 rstt1_valid)
		else $error("rstt1 valid missing");

	t2_valid_lat: assert property (@(posedge clk) disable iff (!rst_n)
		grant[IDX_T2] |-> ##2 rstt2_valid)
		else $error("rstt2 valid missing");

	lc_valid_lat: assert property (@(posedge clk) disable iff (!rst_n)
		grant[IDX_LC] |-> ##2 rstic_valid)
		else $error("rstic valid missing");

	no_grant_on_load: assert property (@(posedge clk) disable iff (!rst_n)
		ld_we |-> (grant == '0))
		else $error("grant during load write");

endmodule : raystore_chk

bind raystore raystore_chk chk_i (
	.clk(clk),
	.rst_n(rst_n),
	.grant(grant),
	.rstt1_stall(rstt1_stall),
	.rstt2_stall(rstt2_stall),
	.rstic_stall(rstic_stall),
	.rstt1_valid(rstt1_valid),
	.rstt2_valid(rstt2_valid),
	.rstic_valid(rstic_valid),
	.ld_we(ld_we)
);

`default_nettype wire

// File: tests/raystore_tb.sv
`default_nettype none

`include "raystore_params.svh"

module raystore_tb import ray_pkg::*, arb_pkg::*; ();

	localparam int STIM_CYCLES = 1100;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

	typedef struct packed {
		int unsigned due;
		ray_id_t id;
		ray_vec_t vec;
	} exp_t;

	logic clk;
	logic rst_n;
	logic reg_wr;
	logic [2:0] reg_addr;
	ray_comp_t reg_wdata;
	ray_id_t ttrs1_id, ttrs2_id, lctrs_id;
	logic ttrs1_re, ttrs2_re, lctrs_re;
	logic ttrs1_stall, ttrs2_stall, lctrs_stall;
	ray_id_t rstt1_id, rstt2_id, rstic_id;
	ray_vec_t rstt1_vec, rstt2_vec, rstic_vec;
	logic rstt1_valid, rstt2_valid, rstic_valid;
	logic rstt1_stall, rstt2_stall, rstic_stall;

	int errors_value;
	int errors_protocol;
	int unsigned cycle;
	integer seed;

	// shadow of the store and of the host staging registers
	ray_vec_t shadow [`RAY_DEPTH];
	ray_id_t stg_id;
	ray_vec_t stg_vec;
	logic ld_we_m;
	grant_mask_t tok;
	grant_mask_t hist1, hist2;
	int all3_run;
	exp_t exp_q [3][$];

	tb_clock #(.PERIOD(8)) clk_i (.clk(clk));

	raystore_top raystore_top_i (.*);

	task automatic check_val(input string name, input logic [191:0] got,
			input logic [191:0] exp);
		if (got !== exp) begin
			errors_value++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic ray_vec_t expected_vec(input ray_id_t id);
		return shadow[id];
	endfunction

	function automatic ray_vec_t make_vec(input ray_id_t id, input logic [7:0] gen);
		ray_vec_t v;
		for (int k = 0; k < 6; k++) begin
			v[(5 - k) * 32 +: 32] = {gen, 8'(k + 1), 10'h2a5, id};
		end
		return v;
	endfunction

	// expected grant from the token rule
	function automatic grant_mask_t predict_grant(input req_mask_t elig, input logic hold,
			input grant_mask_t t);
		if (hold) begin
			return '0;
		end else if (elig == 3'b111) begin
			return t;
		end
		return elig;
	endfunction

	task automatic check_channel(input int ch, input string name, input logic valid,
			input ray_id_t id, input ray_vec_t vec);
		exp_t e;
		if (exp_q[ch].size() > 0 && exp_q[ch][0].due == cycle) begin
			e = exp_q[ch].pop_front();
			if (!valid) begin
				errors_protocol++;
				$display("%s valid missing for ray %0d at cycle %0d", name, e.id, cycle);
			end else begin
				check_val({name, "_id"}, 192'(id), 192'(e.id));
				check_val({name, "_vec"}, vec, e.vec);
			end
		end else if (valid) begin
			errors_protocol++;
			$display("%s valid without a request at cycle %0d", name, cycle);
		end
	endtask

	// reference model, compare and timeout
	always @(posedge clk) begin
		req_mask_t elig;
		grant_mask_t g_exp;
		grant_mask_t g_dut;
		cycle++;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles", cycle);
			$display("value errors: %0d, protocol errors: %0d", errors_value,
				errors_protocol);
			$display("tests failed");
			$finish;
		end else begin
			if (!rst_n) begin
				tok = 3'b110;
				ld_we_m = 1'b0;
				all3_run = 0;
			end else begin
				check_channel(IDX_T1, "rstt1", rstt1_valid, rstt1_id, rstt1_vec);
				check_channel(IDX_T2, "rstt2", rstt2_valid, rstt2_id, rstt2_vec);
				check_channel(IDX_LC, "rstic", rstic_valid, rstic_id, rstic_vec);

				elig = {ttrs1_re & ~rstt1_stall, ttrs2_re & ~rstt2_stall,
					lctrs_re & ~rstic_stall};
				g_exp = predict_grant(elig, ld_we_m, tok);
				g_dut = {~ttrs1_stall, ~ttrs2_stall, ~lctrs_stall};
				check_val("grant", 192'(g_dut), 192'(g_exp));

				if (g_exp[IDX_T1]) begin
					exp_q[IDX_T1].push_back('{cycle + 2, ttrs1_id, expected_vec(ttrs1_id)});
				end
				if (g_exp[IDX_T2]) begin
					exp_q[IDX_T2].push_back('{cycle + 2, ttrs2_id, expected_vec(ttrs2_id)});
				end
				if (g_exp[IDX_LC]) begin
					exp_q[IDX_LC].push_back('{cycle + 2, lctrs_id, expected_vec(lctrs_id)});
				end

				// every requester served within three saturated cycles
				if (elig == 3'b111 && !ld_we_m) begin
					all3_run++;
				end else begin
					all3_run = 0;
				end
				if (all3_run >= 3) begin
					check_val("served_window", 192'(g_dut | hist1 | hist2), 192'(3'b111));
				end
				hist2 = hist1;
				hist1 = g_dut;

				if (ld_we_m) begin
					shadow[stg_id] = stg_vec;
				end
				tok = {tok[0], tok[2:1]};
			end
			ld_we_m = rst_n && reg_wr && (reg_addr == 3'd7);
			if (reg_wr) begin
				if (reg_addr == 3'd0) begin
					stg_id = reg_wdata[`RAY_ID_W-1:0];
				end else if (reg_addr != 3'd7) begin
					stg_vec[(6 - int'(reg_addr)) * 32 +: 32] = reg_wdata;
				end
			end
		end
	end

	task automatic host_write(input logic [2:0] addr, input ray_comp_t data);
		@(posedge clk);
		reg_wr <= 1'b1;
		reg_addr <= addr;
		reg_wdata <= data;
	endtask

	task automatic load_ray(input ray_id_t id, input ray_vec_t vec);
		host_write(3'd0, 32'(id));
		for (int k = 1; k <= 6; k++) begin
			host_write(3'(k), vec[(6 - k) * 32 +: 32]);
		end
		host_write(3'd7, 32'h0);
		@(posedge clk);
		reg_wr <= 1'b0;
	endtask

	task automatic drive_reqs(input logic [2:0] re, input ray_id_t i1, input ray_id_t i2,
			input ray_id_t i3);
		@(posedge clk);
		ttrs1_re <= re[2];
		ttrs2_re <= re[1];
		lctrs_re <= re[0];
		ttrs1_id <= i1;
		ttrs2_id <= i2;
		lctrs_id <= i3;
	endtask

	task automatic idle(input int n);
		for (int k = 0; k < n; k++) begin
			drive_reqs(3'b000, '0, '0, '0);
		end
	endtask

	task automatic random_traffic(input int n);
		logic [31:0] r;
		logic [31:0] s;
		for (int k = 0; k < n; k++) begin
			r = $random(seed);
			s = $random(seed);
			drive_reqs(r[2:0], r[8:3], r[14:9], r[20:15]);
			rstt1_stall <= (s[1:0] == 2'b00);
			rstt2_stall <= (s[3:2] == 2'b00);
			rstic_stall <= (s[5:4] == 2'b00);
		end
		@(posedge clk);
		rstt1_stall <= 1'b0;
		rstt2_stall <= 1'b0;
		rstic_stall <= 1'b0;
	endtask

	initial begin
		seed = 66;
		cycle = 0;
		errors_value = 0;
		errors_protocol = 0;
		rst_n = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		ttrs1_id = '0;
		ttrs2_id = '0;
		lctrs_id = '0;
		ttrs1_re = 1'b0;
		ttrs2_re = 1'b0;
		lctrs_re = 1'b0;
		rstt1_stall = 1'b0;
		rstt2_stall = 1'b0;
		rstic_stall = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		idle(4);

		for (int id = 0; id < `RAY_DEPTH; id++) begin
			load_ray(6'(id), make_vec(6'(id), 8'h01));
		end
		idle(2);

		// single requester reads
		drive_reqs(3'b100, 6'd3, '0, '0);
		drive_reqs(3'b010, '0, 6'd17, '0);
		drive_reqs(3'b001, '0, '0, 6'd63);
		idle(3);

		// every pair of requesters
		drive_reqs(3'b110, 6'd1, 6'd2, '0);
		drive_reqs(3'b011, '0, 6'd4, 6'd5);
		drive_reqs(3'b101, 6'd6, '0, 6'd7);
		idle(3);

		// all three saturated
		for (int k = 0; k < 12; k++) begin
			drive_reqs(3'b111, 6'(k), 6'(k + 20), 6'(k + 40));
		end
		idle(3);

		// commit while traversal 1 keeps reading the same ray
		drive_reqs(3'b111, 6'd9, 6'd10, 6'd11);
		load_ray(6'd9, make_vec(6'd9, 8'h02));
		drive_reqs(3'b100, 6'd9, '0, '0);
		idle(3);

		// list cache output stalled with two results in flight
		drive_reqs(3'b001, '0, '0, 6'd12);
		drive_reqs(3'b001, '0, '0, 6'd13);
		drive_reqs(3'b111, 6'd0, 6'd1, 6'd2);
		rstic_stall <= 1'b1;
		for (int k = 1; k < 8; k++) begin
			drive_reqs(3'b111, 6'(k), 6'(k + 1), 6'(k + 2));
		end
		idle(1);
		rstic_stall <= 1'b0;
		idle(3);

		random_traffic(400);
		idle(6);

		for (int ch = 0; ch < 3; ch++) begin
			if (exp_q[ch].size() != 0) begin
				errors_protocol++;
				$display("channel %0d still has %0d results outstanding", ch,
					exp_q[ch].size());
			end
		end

		$display("value errors: %0d, protocol errors: %0d", errors_value, errors_protocol);
		if (errors_value == 0 && errors_protocol == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule : raystore_tb

`default_nettype wire

// File: compile.f
+incdir+logic
logic/ray_pkg.sv
logic/arb_pkg.sv
logic/rr_arbiter.sv
logic/ray_ram.sv
logic/ray_load_regs.sv
logic/raystore.sv
logic/raystore_top.sv
tests/tb_clock.sv
tests/raystore_chk.sv
tests/raystore_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ray store testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=build

verilator --binary --timing --assert \
	-f compile.f \
	--top-module raystore_tb \
	-Mdir "$BUILD_DIR" \
	-o raystore_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/raystore_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	exit 1
fi

exit 0
